/* design/cpu_macros.svh */
// word-only MIPS subset; opcode values cover R-type, lw and sw and nothing else
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data path width in bits
`define CPU_WORD_W 32

// architectural register count
`define CPU_REG_N 32

// primary opcode field values
`define CPU_OP_RTYPE 6'h00
`define CPU_OP_LW 6'h23
`define CPU_OP_SW 6'h2b

`endif

/* design/cpu_types_pkg.sv */
// types for the MEM/WB back end; word width follows CPU_WORD_W and must stay 32 for the decode
`include "cpu_macros.svh"

package cpu_types_pkg;

	// basic data path types
	typedef logic [`CPU_WORD_W-1:0] word_t;
	typedef logic [4:0] regbits_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	// R-type field layout
	typedef struct packed {
		opcode_t opcode;
		regbits_t rs;
		regbits_t rt;
		regbits_t rd;
		logic [4:0] shamt;
		funct_t funct;
	} instr_r_t;

	// I-type field layout
	typedef struct packed {
		opcode_t opcode;
		regbits_t rs;
		regbits_t rt;
		logic [15:0] imm16;
	} instr_i_t;

	// one instruction word, two views of it
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	// writeback source select
	typedef enum logic {
		WB_ALU = 1'b0,
		WB_MEM = 1'b1
	} wb_src_t;

endpackage

/* design/pipe_if.sv */
// internal bundles only; Wishbone sel is always all ones and no tags or errors are carried
`timescale 1ns/1ns
`include "cpu_macros.svh"

// stage outputs toward MEM/WB, and the latched copies toward writeback
interface mem_wb_if;
	logic valid;
	cpu_types_pkg::word_t pc;
	cpu_types_pkg::word_t instr;
	cpu_types_pkg::word_t result;
	cpu_types_pkg::word_t load_data;
	logic wen;
	cpu_types_pkg::regbits_t dest;
	cpu_types_pkg::wb_src_t src;
	logic halt;
	logic enable;

	// latched side
	logic valid_q;
	cpu_types_pkg::word_t pc_q;
	cpu_types_pkg::word_t instr_q;
	cpu_types_pkg::word_t result_q;
	cpu_types_pkg::word_t load_data_q;
	logic wen_q;
	cpu_types_pkg::regbits_t dest_q;
	cpu_types_pkg::wb_src_t src_q;
	logic halt_q;

	modport stage (
		output valid, pc, instr, result, load_data, wen, dest, src, halt, enable
	);

	modport reg_side (
		input valid, pc, instr, result, load_data, wen, dest, src, halt, enable,
		output valid_q, pc_q, instr_q, result_q, load_data_q, wen_q, dest_q, src_q, halt_q
	);

	modport wb_side (
		input valid_q, pc_q, instr_q, result_q, load_data_q, wen_q, dest_q, src_q, halt_q
	);
endinterface

// Wishbone classic data bus
interface wb_bus_if;
	logic cyc;
	logic stb;
	logic we;
	logic [`CPU_WORD_W-1:0] adr;
	logic [`CPU_WORD_W-1:0] dat_o;
	logic [`CPU_WORD_W-1:0] dat_i;
	logic [`CPU_WORD_W/8-1:0] sel;
	logic ack;

	modport master (output cyc, stb, we, adr, dat_o, sel, input dat_i, ack);
	modport slave (input cyc, stb, we, adr, dat_o, sel, output dat_i, ack);
endinterface

/* design/mem_stage.sv */
// upstream must hold the ex_ inputs while stall is high; word accesses only, no bus error handling
`timescale 1ns/1ns
`include "cpu_macros.svh"

module mem_stage (
	input logic CLK,
	input logic nRST,
	input logic ex_valid,
	input logic ex_wen,
	input logic ex_halt,
	input cpu_types_pkg::word_t ex_pc,
	input cpu_types_pkg::word_t ex_instr,
	input cpu_types_pkg::word_t ex_result,
	input cpu_types_pkg::word_t ex_store_data,
	output logic stall,
	wb_bus_if.master bus,
	mem_wb_if.stage pipe
);

	cpu_types_pkg::instr_u iu;
	cpu_types_pkg::opcode_t opcode;
	logic is_rtype;
	logic is_lw;
	logic is_sw;
	logic is_mem;
	logic busy;
	logic done;

	// decode
	assign iu = ex_instr;
	assign opcode = iu.r.opcode;
	assign is_rtype = (opcode == `CPU_OP_RTYPE);
	assign is_lw = (opcode == `CPU_OP_LW);
	assign is_sw = (opcode == `CPU_OP_SW);
	assign is_mem = ex_valid && (is_lw || is_sw);

	// bus cycle finishes on an acked edge while open
	assign done = busy && bus.ack;

	// one cycle of setup, then cyc/stb held until ack
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			busy <= 1'b0;
		end else if (done) begin
			busy <= 1'b0;
		end else if (is_mem) begin
			busy <= 1'b1;
		end
	end

	assign bus.cyc = busy;
	assign bus.stb = busy;
	assign bus.we = is_sw;
	assign bus.adr = ex_result;
	assign bus.dat_o = ex_store_data;
	assign bus.sel = '1;

	// hold upstream until the ack cycle
	assign stall = is_mem && !done;

	// advance into MEM/WB for non-memory work or on ack
	assign pipe.enable = is_mem ? done : 1'b1;

	assign pipe.valid = ex_valid;
	assign pipe.pc = ex_pc;
	assign pipe.instr = ex_instr;
	assign pipe.result = ex_result;
	assign pipe.load_data = bus.dat_i;
	// stores never write a register
	assign pipe.wen = ex_wen && !is_sw;
	assign pipe.dest = is_rtype ? iu.r.rd : iu.i.rt;
	assign pipe.src = is_lw ? cpu_types_pkg::WB_MEM : cpu_types_pkg::WB_ALU;
	assign pipe.halt = ex_valid && ex_halt;

endmodule

/* design/mem_wb_reg.sv */
// flush wins over enable and loads a cleared bubble; all fields reset to zero
`timescale 1ns/1ns

module mem_wb_reg (
	input logic CLK,
	input logic nRST,
	input logic flush,
	mem_wb_if.reg_side pipe_in
);

	logic valid_reg, valid_nxt;
	logic wen_reg, wen_nxt;
	logic halt_reg, halt_nxt;
	cpu_types_pkg::word_t pc_reg, pc_nxt;
	cpu_types_pkg::word_t instr_reg, instr_nxt;
	cpu_types_pkg::word_t result_reg, result_nxt;
	cpu_types_pkg::word_t load_data_reg, load_data_nxt;
	cpu_types_pkg::regbits_t dest_reg, dest_nxt;
	cpu_types_pkg::wb_src_t src_reg, src_nxt;

	assign pipe_in.valid_q = valid_reg;
	assign pipe_in.wen_q = wen_reg;
	assign pipe_in.halt_q = halt_reg;
	assign pipe_in.pc_q = pc_reg;
	assign pipe_in.instr_q = instr_reg;
	assign pipe_in.result_q = result_reg;
	assign pipe_in.load_data_q = load_data_reg;
	assign pipe_in.dest_q = dest_reg;
	assign pipe_in.src_q = src_reg;

	always_comb begin
		// hold by default
		valid_nxt = valid_reg;
		wen_nxt = wen_reg;
		halt_nxt = halt_reg;
		pc_nxt = pc_reg;
		instr_nxt = instr_reg;
		result_nxt = result_reg;
		load_data_nxt = load_data_reg;
		dest_nxt = dest_reg;
		src_nxt = src_reg;

		if (flush) begin
			// bubble
			valid_nxt = 1'b0;
			wen_nxt = 1'b0;
			halt_nxt = 1'b0;
			pc_nxt = '0;
			instr_nxt = '0;
			result_nxt = '0;
			load_data_nxt = '0;
			dest_nxt = '0;
			src_nxt = cpu_types_pkg::WB_ALU;
		end else if (pipe_in.enable) begin
			valid_nxt = pipe_in.valid;
			wen_nxt = pipe_in.wen;
			halt_nxt = pipe_in.halt;
			pc_nxt = pipe_in.pc;
			instr_nxt = pipe_in.instr;
			result_nxt = pipe_in.result;
			load_data_nxt = pipe_in.load_data;
			dest_nxt = pipe_in.dest;
			src_nxt = pipe_in.src;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_reg <= 1'b0;
			wen_reg <= 1'b0;
			halt_reg <= 1'b0;
			pc_reg <= '0;
			instr_reg <= '0;
			result_reg <= '0;
			load_data_reg <= '0;
			dest_reg <= '0;
			src_reg <= cpu_types_pkg::WB_ALU;
		end else begin
			valid_reg <= valid_nxt;
			wen_reg <= wen_nxt;
			halt_reg <= halt_nxt;
			pc_reg <= pc_nxt;
			instr_reg <= instr_nxt;
			result_reg <= result_nxt;
			load_data_reg <= load_data_nxt;
			dest_reg <= dest_nxt;
			src_reg <= src_nxt;
		end
	end

endmodule

/* design/reg_file.sv */
// one write port, one combinational read port; register 0 is hardwired to zero
`timescale 1ns/1ns
`include "cpu_macros.svh"

module reg_file (
	input logic CLK,
	input logic nRST,
	input logic we,
	input cpu_types_pkg::regbits_t waddr,
	input cpu_types_pkg::regbits_t raddr,
	input cpu_types_pkg::word_t wdata,
	output cpu_types_pkg::word_t rdata
);

	cpu_types_pkg::word_t regs [`CPU_REG_N];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < `CPU_REG_N; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// read path, no bypass of a same-cycle write
	always_comb begin
		if (raddr == '0) begin
			rdata = '0;
		end else begin
			rdata = regs[raddr];
		end
	end

endmodule

/* design/writeback_unit.sv */
// register write lands one edge after MEM/WB latches; retire trace mirrors the latched fields
`timescale 1ns/1ns

module writeback_unit (
	input logic CLK,
	input logic nRST,
	mem_wb_if.wb_side pipe,
	input cpu_types_pkg::regbits_t rs_addr,
	output cpu_types_pkg::word_t rs_data,
	output logic retire_valid,
	output logic halt,
	output cpu_types_pkg::word_t retire_pc,
	output cpu_types_pkg::word_t retire_instr
);

	logic reg_we;
	cpu_types_pkg::word_t wdata;

	// result select
	always_comb begin
		if (pipe.src_q == cpu_types_pkg::WB_MEM) begin
			wdata = pipe.load_data_q;
		end else begin
			wdata = pipe.result_q;
		end
	end

	// bubbles never write
	assign reg_we = pipe.wen_q && pipe.valid_q;

	reg_file u_reg_file (
		.CLK(CLK),
		.nRST(nRST),
		.we(reg_we),
		.waddr(pipe.dest_q),
		.wdata(wdata),
		.raddr(rs_addr),
		.rdata(rs_data)
	);

	// retire trace
	assign retire_valid = pipe.valid_q;
	assign retire_pc = pipe.pc_q;
	assign retire_instr = pipe.instr_q;
	assign halt = pipe.halt_q;

endmodule

/* design/mem_wb_top.sv */
// EX/MEM bundle in, Wishbone classic master out; ex_ inputs must stay steady while stall is high
`timescale 1ns/1ns
`include "cpu_macros.svh"

module mem_wb_top (
	input logic CLK,
	input logic nRST,
	input logic ex_valid,
	input cpu_types_pkg::word_t ex_pc,
	input cpu_types_pkg::word_t ex_instr,
	input cpu_types_pkg::word_t ex_result,
	input cpu_types_pkg::word_t ex_store_data,
	input logic ex_wen,
	input logic ex_halt,
	input logic flush,
	output logic stall,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [`CPU_WORD_W-1:0] wb_adr,
	output logic [`CPU_WORD_W-1:0] wb_dat_o,
	output logic [`CPU_WORD_W/8-1:0] wb_sel,
	input logic [`CPU_WORD_W-1:0] wb_dat_i,
	input logic wb_ack,
	input cpu_types_pkg::regbits_t rs_addr,
	output cpu_types_pkg::word_t rs_data,
	output logic retire_valid,
	output cpu_types_pkg::word_t retire_pc,
	output cpu_types_pkg::word_t retire_instr,
	output logic halt
);

	wb_bus_if bus ();
	mem_wb_if pipe ();

	// Wishbone pins
	assign wb_cyc = bus.cyc;
	assign wb_stb = bus.stb;
	assign wb_we = bus.we;
	assign wb_adr = bus.adr;
	assign wb_dat_o = bus.dat_o;
	assign wb_sel = bus.sel;
	assign bus.dat_i = wb_dat_i;
	assign bus.ack = wb_ack;

	mem_stage u_mem_stage (
		.CLK(CLK),
		.nRST(nRST),
		.ex_valid(ex_valid),
		.ex_wen(ex_wen),
		.ex_halt(ex_halt),
		.ex_pc(ex_pc),
		.ex_instr(ex_instr),
		.ex_result(ex_result),
		.ex_store_data(ex_store_data),
		.stall(stall),
		.bus(bus.master),
		.pipe(pipe.stage)
	);

	mem_wb_reg u_mem_wb_reg (
		.CLK(CLK),
		.nRST(nRST),
		.flush(flush),
		.pipe_in(pipe.reg_side)
	);

	writeback_unit u_writeback_unit (
		.CLK(CLK),
		.nRST(nRST),
		.pipe(pipe.wb_side),
		.rs_addr(rs_addr),
		.rs_data(rs_data),
		.retire_valid(retire_valid),
		.halt(halt),
		.retire_pc(retire_pc),
		.retire_instr(retire_instr)
	);

endmodule

/* bench/mem_wb_props.sv */
// bound into mem_stage; sampled on the rising CLK edge, quiet while nRST is low
`timescale 1ns/1ns
`include "cpu_macros.svh"

module mem_wb_props (
	input logic CLK,
	input logic nRST,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic ack,
	input logic [`CPU_WORD_W-1:0] adr,
	input logic stall,
	input logic enable
);

	// bus cycle closes right after the acked edge
	a_cyc_close: assert property (@(posedge CLK) disable iff (!nRST)
		(cyc && ack) |=> (!cyc && !stb))
		else $error("wishbone cyc or stb still high after the ack edge");

	// request held until the slave answers
	a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
		(stb && !ack) |=> ($stable(adr) && $stable(we)))
		else $error("wishbone adr or we changed before ack");

	a_stall_reset: assert property (@(posedge CLK) $rose(nRST) |-> !stall)
		else $error("stall high on the first edge after reset");

	// MEM/WB advances only with no open cycle or on the ack
	a_enable_ack: assert property (@(posedge CLK) disable iff (!nRST) enable |-> (!cyc || ack))
		else $error("pipeline enable during an open bus cycle without ack");

endmodule

bind mem_stage mem_wb_props u_mem_wb_props (
	.CLK(CLK),
	.nRST(nRST),
	.cyc(bus.cyc),
	.stb(bus.stb),
	.we(bus.we),
	.ack(bus.ack),
	.adr(bus.adr),
	.stall(stall),
	.enable(pipe.enable)
);

/* bench/mem_wb_tb.sv */
// one DUT run; slave memory decodes adr[7:2] only, so word addresses alias every 256 bytes
`timescale 1ns/1ns
`include "cpu_macros.svh"

module mem_wb_tb;

	localparam int NUM_ENTRIES = 16;
	localparam int WATCHDOG_CYCLES = NUM_ENTRIES * 8 + 100;
	localparam logic [1:0] K_ALU_R = 2'd0;
	localparam logic [1:0] K_ALU_I = 2'd1;
	localparam logic [1:0] K_LW = 2'd2;
	localparam logic [1:0] K_SW = 2'd3;

	// kind, dest field, result or address, store data, wen, flush, halt
	typedef struct packed {
		logic [1:0] kind;
		logic [4:0] dest;
		logic [31:0] value;
		logic [31:0] sdata;
		logic wen;
		logic flush;
		logic halt;
	} entry_t;

	logic CLK;
	logic nRST;
	logic ex_valid, ex_wen, ex_halt, flush;
	cpu_types_pkg::word_t ex_pc, ex_instr, ex_result, ex_store_data;
	logic stall, wb_cyc, wb_stb, wb_we, wb_ack;
	logic [`CPU_WORD_W-1:0] wb_adr, wb_dat_o, wb_dat_i;
	logic [`CPU_WORD_W/8-1:0] wb_sel;
	cpu_types_pkg::regbits_t rs_addr;
	cpu_types_pkg::word_t rs_data, retire_pc, retire_instr;
	logic retire_valid, halt;

	entry_t tbl [NUM_ENTRIES];
	cpu_types_pkg::word_t slave_mem [64];
	cpu_types_pkg::word_t exp_mem [64];
	cpu_types_pkg::word_t model [`CPU_REG_N];
	logic [31:0] lcg_state;
	logic [1:0] wait_left;
	logic armed;
	logic ack_q;
	cpu_types_pkg::word_t rdata_q;
	int err_count;
	int check_count;

	mem_wb_top u_mem_wb_top (.*);

	initial CLK = 1'b0;
	always #2 CLK = ~CLK;

	function automatic cpu_types_pkg::word_t fill_word(int idx);
		return {8'h5a, 6'(idx), 12'h000, 6'(idx)};
	endfunction

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// rd and rt always differ, so a wrong view picks the wrong register
	function automatic cpu_types_pkg::word_t build_instr(entry_t e, int idx);
		case (e.kind)
			K_ALU_R: return {`CPU_OP_RTYPE, 5'd1, e.dest ^ 5'h15, e.dest, 5'd0, 6'h20};
			K_ALU_I: return {6'h08, 5'd1, e.dest, e.dest ^ 5'h0a, 11'(idx)};
			K_LW: return {`CPU_OP_LW, 5'd2, e.dest, e.dest ^ 5'h0a, 11'(idx)};
			default: return {`CPU_OP_SW, 5'd2, e.dest, e.dest ^ 5'h0a, 11'(idx)};
		endcase
	endfunction

	// wishbone slave with a registered ack after 0 to 3 random wait states
	assign wb_ack = ack_q && nRST;
	assign wb_dat_i = nRST ? rdata_q : '0;

	always @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			ack_q <= 1'b0;
			armed <= 1'b0;
			wait_left <= 2'd0;
			rdata_q <= '0;
			lcg_state <= 32'h9bb7;
			for (int a = 0; a < 64; a++) begin
				slave_mem[a] <= fill_word(a);
			end
		end else if (ack_q) begin
			ack_q <= 1'b0;
			armed <= 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!armed) begin
				armed <= 1'b1;
				wait_left <= lcg_state[17:16];
				lcg_state <= lcg_next(lcg_state);
			end else if (wait_left != 2'd0) begin
				wait_left <= wait_left - 2'd1;
			end else begin
				ack_q <= 1'b1;
				rdata_q <= slave_mem[wb_adr[7:2]];
				if (wb_we) begin
					slave_mem[wb_adr[7:2]] <= wb_dat_o;
				end
			end
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERR %0t ns %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// stores land even when flushed since the bus cycle is never aborted
	task automatic update_model(input entry_t e);
		if (e.kind == K_SW) begin
			exp_mem[e.value[7:2]] = e.sdata;
		end else if (!e.flush && e.wen && e.dest != 5'd0) begin
			model[e.dest] = (e.kind == K_LW) ? exp_mem[e.value[7:2]] : e.value;
		end
	endtask

	task automatic load_table();
		tbl[0] = '{K_ALU_R, 5'd3, 32'h1234_5678, 32'h0, 1'b1, 1'b0, 1'b0};
		tbl[1] = '{K_ALU_I, 5'd7, 32'hcafe_0001, 32'h0, 1'b1, 1'b0, 1'b0};
		tbl[2] = '{K_LW, 5'd9, 32'h0000_0010, 32'h0, 1'b1, 1'b0, 1'b0};
		tbl[3] = '{K_SW, 5'd3, 32'h0000_0020, 32'hdead_beef, 1'b1, 1'b0, 1'b0};
		tbl[4] = '{K_LW, 5'd10, 32'h0000_0020, 32'h0, 1'b1, 1'b0, 1'b0};
		tbl[5] = '{K_ALU_R, 5'd0, 32'hffff_ffff, 32'h0, 1'b1, 1'b0, 1'b0};
		tbl[6] = '{K_ALU_I, 5'd12, 32'h5555_aaaa, 32'h0, 1'b1, 1'b1, 1'b0};
		tbl[7] = '{K_LW, 5'd13, 32'h0000_003c, 32'h0, 1'b1, 1'b1, 1'b0};
		tbl[8] = '{K_ALU_R, 5'd14, 32'h0bad_f00d, 32'h0, 1'b1, 1'b0, 1'b1};
		tbl[9] = '{K_LW, 5'd0, 32'h0000_0008, 32'h0, 1'b1, 1'b0, 1'b0};
		tbl[10] = '{K_ALU_I, 5'd15, 32'h0000_0001, 32'h0, 1'b0, 1'b0, 1'b0};
		tbl[11] = '{K_SW, 5'd16, 32'h0000_00fc, 32'h0123_4567, 1'b1, 1'b0, 1'b0};
		tbl[12] = '{K_LW, 5'd16, 32'h0000_00fc, 32'h0, 1'b1, 1'b0, 1'b0};
		tbl[13] = '{K_ALU_R, 5'd7, 32'h7777_0000, 32'h0, 1'b1, 1'b0, 1'b0};
		tbl[14] = '{K_LW, 5'd20, 32'h0000_0044, 32'h0, 1'b1, 1'b0, 1'b1};
		tbl[15] = '{K_LW, 5'd21, 32'h0000_0020, 32'h0, 1'b1, 1'b0, 1'b0};
	endtask

	initial begin
		entry_t e;
		cpu_types_pkg::word_t instr;
		logic is_mem;
		err_count = 0;
		check_count = 0;
		nRST = 1'b0;
		ex_valid = 1'b0;
		ex_pc = '0;
		ex_instr = '0;
		ex_result = '0;
		ex_store_data = '0;
		ex_wen = 1'b0;
		ex_halt = 1'b0;
		flush = 1'b0;
		rs_addr = '0;
		load_table();
		for (int r = 0; r < `CPU_REG_N; r++) begin
			model[r] = '0;
		end
		for (int a = 0; a < 64; a++) begin
			exp_mem[a] = fill_word(a);
		end
		repeat (10) @(posedge CLK);
		nRST <= 1'b1;
		// every register reads zero after reset
		for (int r = 0; r < `CPU_REG_N; r++) begin
			@(posedge CLK);
			rs_addr <= 5'(r);
			#1;
			check("rs_data", rs_data, 32'h0);
		end
		check("stall", 32'(stall), 32'd0);
		check("wb_cyc", 32'(wb_cyc), 32'd0);
		check("wb_stb", 32'(wb_stb), 32'd0);
		check("retire_valid", 32'(retire_valid), 32'd0);
		check("halt", 32'(halt), 32'd0);
		for (int idx = 0; idx < NUM_ENTRIES; idx++) begin
			e = tbl[idx];
			instr = build_instr(e, idx);
			is_mem = (e.kind == K_LW) || (e.kind == K_SW);
			@(posedge CLK);
			ex_valid <= 1'b1;
			ex_pc <= 32'h0000_0400 + 32'(idx) * 32'd4;
			ex_instr <= instr;
			ex_result <= e.value;
			ex_store_data <= e.sdata;
			ex_wen <= e.wen;
			ex_halt <= e.halt;
			flush <= e.flush;
			#1;
			check("stall", 32'(stall), 32'(is_mem));
			while (stall) begin
				@(posedge CLK);
				#1;
			end
			// stall dropped, so this must be the ack cycle
			if (is_mem) begin
				check("wb_ack", 32'(wb_ack), 32'd1);
				check("wb_cyc", 32'(wb_cyc), 32'd1);
				check("wb_stb", 32'(wb_stb), 32'd1);
				check("wb_adr", wb_adr, e.value);
				check("wb_sel", 32'(wb_sel), 32'hf);
				check("wb_we", 32'(wb_we), 32'(e.kind == K_SW));
				if (e.kind == K_SW) begin
					check("wb_dat_o", wb_dat_o, e.sdata);
				end
			end
			@(posedge CLK);
			ex_valid <= 1'b0;
			ex_halt <= 1'b0;
			flush <= 1'b0;
			rs_addr <= e.dest;
			update_model(e);
			#1;
			check("retire_valid", 32'(retire_valid), 32'(!e.flush));
			check("halt", 32'(halt), 32'(e.halt && !e.flush));
			if (!e.flush) begin
				check("retire_pc", retire_pc, 32'h0000_0400 + 32'(idx) * 32'd4);
				check("retire_instr", retire_instr, instr);
			end
			@(posedge CLK);
			#1;
			check("rs_data", rs_data, model[e.dest]);
			check("halt", 32'(halt), 32'd0);
		end
		$display("run complete: %0d checks, %0d errors", check_count, err_count);
		if (err_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("timeout: the entry table did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

endmodule

/* tb.f */
+incdir+design
design/cpu_types_pkg.sv
design/pipe_if.sv
design/mem_stage.sv
design/mem_wb_reg.sv
design/reg_file.sv
design/writeback_unit.sv
design/mem_wb_top.sv
bench/mem_wb_props.sv
bench/mem_wb_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP ?= mem_wb_tb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= Testbench failed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
